/* verilog.f */
logic/frontend_pkg.sv
logic/fetch_if.sv
logic/fetch.sv
logic/predecode.sv
logic/issue_queue.sv
logic/frontend_top.sv
verif/frontend_tb.sv

/* verif/frontend_trace.txt */
# m addr word : memory words, all others hold addi x0,x0,addr | e pc instr class tag : issue
# t name count kind jump_target mtvec mepc stall : class 0 alu .. 5 jal .. 9 system, a illegal
m 00 00100093
m 04 002081b3
m 08 0000a203
m 0c 0040a223
m 10 00208463
m 14 123452b7
m 18 0100006f
m 28 00000317
m 2c 0000007f
m 30 00000073
t sequential 6 none 0 0 0 0
e 00 00100093 1 0
e 04 002081b3 0 0
e 08 0000a203 2 0
e 0c 0040a223 3 0
e 10 00208463 4 0
e 14 123452b7 7 0
t fe_jal 3 none 0 0 0 0
e 18 0100006f 5 0
e 28 00000317 8 1
e 2c 0000007f a 1
t be_jump 2 jump 40 80 60 0
e 40 04000013 1 2
e 44 04400013 1 2
t exception 2 exception 40 80 60 0
e 80 08000013 1 3
e 84 08400013 1 3
t interrupt 2 interrupt 40 80 60 0
e 80 08000013 1 4
e 84 08400013 1 4
t backpressure 9 jump 00 80 60 1
e 00 00100093 1 5
e 04 002081b3 0 5
e 08 0000a203 2 5
e 0c 0040a223 3 5
e 10 00208463 4 5
e 14 123452b7 7 5
e 18 0100006f 5 5
e 28 00000317 8 6
e 2c 0000007f a 6
t mret_priority 2 mret 40 80 60 0
e 60 06000013 1 7
e 64 06400013 1 7
t illegal_opcode 2 jump 2c 80 60 0
e 2c 0000007f a 0
e 30 00000073 9 0

/* verif/frontend_tb.sv */
// testbench for the front end: wishbone memory model, trace-driven redirects and issue checks
`timescale 1ns/1ps
`default_nettype none

module frontend_tb;

    logic                    clk;
    logic                    reset;
    logic                    wb_cyc_o;
    logic                    wb_stb_o;
    logic                    wb_we_o;
    logic [31:0]             wb_adr_o;
    logic [31:0]             wb_dat_i;
    logic                    wb_ack_i;
    logic                    jump_i;
    logic [31:0]             jump_target_i;
    logic                    exception_raised_i;
    logic                    interrupt_ack_i;
    logic                    machine_return_i;
    logic [31:0]             mtvec_i;
    logic [31:0]             mepc_i;
    logic                    issue_ready_i;
    logic                    issue_valid_o;
    logic [31:0]             issue_pc_o;
    logic [31:0]             issue_instruction_o;
    frontend_pkg::op_class_e issue_class_o;
    logic [2:0]              issue_tag_o;

    // instruction memory seen by the wishbone slave model
    logic [31:0] mem [64];

    // tests and expected issue stream from the trace
    string       test_name[$];
    string       test_kind[$];
    int          test_count[$];
    int          test_stall[$];
    logic [31:0] test_jump[$];
    logic [31:0] test_mtvec[$];
    logic [31:0] test_mepc[$];
    logic [31:0] exp_pc[$];
    logic [31:0] exp_instr[$];
    logic [3:0]  exp_class[$];
    logic [2:0]  exp_tag[$];

    integer      seed = 32'hc2e8;
    int          error_count = 0;
    int          test_errors = 0;
    int          watchdog_cycles = 0;
    // slave model state
    logic        in_read = 1'b0;
    int          delay_left = 0;
    logic [31:0] read_adr = '0;
    // ack was high in the cycle just sampled
    logic        after_ack = 1'b0;
    // outputs seen with valid high and ready low must hold
    logic        hold_pending = 1'b0;
    logic [70:0] held_entry;

    frontend_top #(
        .start_address (32'h0000_0000),
        .queue_depth   (4)
    ) DUT (
        .clk                 (clk),
        .reset               (reset),
        .wb_cyc_o            (wb_cyc_o),
        .wb_stb_o            (wb_stb_o),
        .wb_we_o             (wb_we_o),
        .wb_adr_o            (wb_adr_o),
        .wb_dat_i            (wb_dat_i),
        .wb_ack_i            (wb_ack_i),
        .jump_i              (jump_i),
        .jump_target_i       (jump_target_i),
        .exception_raised_i  (exception_raised_i),
        .interrupt_ack_i     (interrupt_ack_i),
        .machine_return_i    (machine_return_i),
        .mtvec_i             (mtvec_i),
        .mepc_i              (mepc_i),
        .issue_ready_i       (issue_ready_i),
        .issue_valid_o       (issue_valid_o),
        .issue_pc_o          (issue_pc_o),
        .issue_instruction_o (issue_instruction_o),
        .issue_class_o       (issue_class_o),
        .issue_tag_o         (issue_tag_o)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    // memory image first, then test headers and their expected issues
    task automatic load_trace();
        int          fd;
        int          status;
        string       line;
        string       name;
        string       kind;
        int          count;
        int          stall;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        logic [31:0] d;
        // words not in the trace hold addi x0, x0, address
        for (int i = 0; i < 64; i++) begin
            mem[i] = ((i * 4) << 20) | 32'h0000_0013;
        end
        fd = $fopen("verif/frontend_trace.txt", "r");
        if (fd == 0) begin
            $display("cannot open the trace file verif/frontend_trace.txt");
            $display("Errors found");
            $finish;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                status = $fgets(line, fd);
                if (line.len() < 2 || line[0] == "#") begin
                    continue;
                end
                if (line[0] == "m") begin
                    if ($sscanf(line, "m %h %h", a, b) == 2) begin
                        mem[a[7:2]] = b;
                    end
                end else if (line[0] == "t") begin
                    status = $sscanf(line, "t %s %d %s %h %h %h %d",
                                     name, count, kind, a, b, c, stall);
                    test_name.push_back(name);
                    test_count.push_back(count);
                    test_kind.push_back(kind);
                    test_jump.push_back(a);
                    test_mtvec.push_back(b);
                    test_mepc.push_back(c);
                    test_stall.push_back(stall);
                end else if (line[0] == "e") begin
                    status = $sscanf(line, "e %h %h %h %h", a, b, c, d);
                    exp_pc.push_back(a);
                    exp_instr.push_back(b);
                    exp_class.push_back(c[3:0]);
                    exp_tag.push_back(d[2:0]);
                end
            end
            $fclose(fd);
        end
    endtask

    // ready pattern, mostly low in stall tests
    function automatic logic draw_ready(input int stall);
        int r;
        r = $unsigned($random(seed)) % 8;
        if (stall != 0) begin
            return (r == 0);
        end
        return (r < 5);
    endfunction

    // wishbone classic slave, ack after 0 to 3 extra cycles
    task automatic serve_bus();
        assert (!(wb_cyc_o && wb_we_o)) else begin
            $display("write cycle seen on the instruction bus at %h", wb_adr_o);
            error_count++;
        end
        assert (wb_stb_o === wb_cyc_o) else begin
            $display("wishbone stb and cyc differ at address %h", wb_adr_o);
            error_count++;
        end
        // cyc and stb drop in the cycle after ack
        if (after_ack) begin
            assert (!wb_cyc_o) else begin
                $display("wishbone cycle still open in the cycle after ack at %h", wb_adr_o);
                error_count++;
            end
        end
        after_ack = wb_ack_i;
        if (wb_ack_i) begin
            wb_ack_i <= 1'b0;
            in_read = 1'b0;
        end else if (wb_cyc_o && wb_stb_o) begin
            if (!in_read) begin
                in_read = 1'b1;
                read_adr = wb_adr_o;
                delay_left = $unsigned($random(seed)) % 4;
            end else begin
                // address holds until ack
                assert (wb_adr_o === read_adr) else begin
                    $display("wishbone address moved from %h to %h before ack",
                             read_adr, wb_adr_o);
                    error_count++;
                end
            end
            if (delay_left == 0) begin
                wb_ack_i <= 1'b1;
                wb_dat_i <= mem[wb_adr_o[7:2]];
            end else begin
                delay_left = delay_left - 1;
            end
        end
    endtask

    task automatic step_cycle();
        @(posedge clk);
        serve_bus();
    endtask

    task automatic check_value(input string test, input string field,
                               input logic [31:0] expected, input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("MISMATCH %s %s expected %h actual %h", test, field, expected, actual);
            error_count++;
            test_errors++;
        end
    endtask

    // runs cycles until one transfer on the issue port, returns its fields
    task automatic wait_issue(input string test, input int stall,
                              output logic [31:0] pc, output logic [31:0] instr,
                              output logic [3:0] cls, output logic [2:0] tag);
        logic [70:0] now;
        logic        done;
        done = 1'b0;
        while (!done) begin
            step_cycle();
            now = {issue_pc_o, issue_instruction_o, issue_class_o, issue_tag_o};
            if (hold_pending) begin
                assert (issue_valid_o && now == held_entry) else begin
                    $display("%s: issue outputs changed while valid was high and ready low",
                             test);
                    error_count++;
                    test_errors++;
                end
            end
            hold_pending = issue_valid_o && !issue_ready_i;
            held_entry = now;
            if (issue_valid_o && issue_ready_i) begin
                done = 1'b1;
                pc = issue_pc_o;
                instr = issue_instruction_o;
                cls = issue_class_o;
                tag = issue_tag_o;
            end
            issue_ready_i <= draw_ready(stall);
        end
    endtask

    // one cycle redirect pulse, ready held low so nothing stale issues meanwhile
    task automatic apply_redirect(input int t);
        issue_ready_i <= 1'b0;
        jump_target_i <= test_jump[t];
        mtvec_i <= test_mtvec[t];
        mepc_i <= test_mepc[t];
        if (test_kind[t] == "jump") begin
            jump_i <= 1'b1;
        end else if (test_kind[t] == "exception") begin
            exception_raised_i <= 1'b1;
        end else if (test_kind[t] == "interrupt") begin
            interrupt_ack_i <= 1'b1;
        end else if (test_kind[t] == "mret") begin
            // all three at once, mepc must win
            machine_return_i <= 1'b1;
            exception_raised_i <= 1'b1;
            jump_i <= 1'b1;
        end
        step_cycle();
        jump_i <= 1'b0;
        exception_raised_i <= 1'b0;
        interrupt_ack_i <= 1'b0;
        machine_return_i <= 1'b0;
        hold_pending = 1'b0;
        issue_ready_i <= draw_ready(test_stall[t]);
    endtask

    initial begin
        int          idx;
        int          fails;
        logic [31:0] pc;
        logic [31:0] instr;
        logic [3:0]  cls;
        logic [2:0]  tag;
        reset = 1'b1;
        wb_dat_i = '0;
        wb_ack_i = 1'b0;
        jump_i = 1'b0;
        jump_target_i = '0;
        exception_raised_i = 1'b0;
        interrupt_ack_i = 1'b0;
        machine_return_i = 1'b0;
        mtvec_i = '0;
        mepc_i = '0;
        issue_ready_i = 1'b0;
        load_trace();
        watchdog_cycles = 40 * exp_pc.size() + 40;
        repeat (10) step_cycle();
        reset <= 1'b0;
        idx = 0;
        fails = 0;
        for (int t = 0; t < test_name.size(); t++) begin
            test_errors = 0;
            if (test_kind[t] != "none") begin
                apply_redirect(t);
            end
            for (int k = 0; k < test_count[t]; k++) begin
                wait_issue(test_name[t], test_stall[t], pc, instr, cls, tag);
                check_value(test_name[t], "pc", exp_pc[idx], pc);
                check_value(test_name[t], "instruction", exp_instr[idx], instr);
                check_value(test_name[t], "class", exp_class[idx], cls);
                check_value(test_name[t], "tag", exp_tag[idx], tag);
                idx++;
            end
            if (test_errors != 0) begin
                fails++;
            end
            $display("test %s: %0d issued, %0d wrong values, %s", test_name[t],
                     test_count[t], test_errors, (test_errors == 0) ? "pass" : "fail");
        end
        $display("tests %0d, failing %0d, total errors %0d", test_name.size(), fails,
                 error_count);
        if (error_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    // watchdog, sized from the number of expected issues
    initial begin
        wait (watchdog_cycles > 0);
        repeat (watchdog_cycles) @(posedge clk);
        $display("timeout: the issue stream stopped before the trace was complete");
        $display("Errors found");
        $finish;
    end

endmodule

`default_nettype wire

/* logic/frontend_top.sv */
// front-end top level: fetch, predecoder and issue queue behind plain ports
`timescale 1ns/1ps
`default_nettype none

module frontend_top #(
    parameter logic [frontend_pkg::xlen-1:0] start_address = '0,
    parameter int                            queue_depth   = 4
) (
    input  wire logic                                clk,
    input  wire logic                                reset,
    // wishbone classic read master
    output      logic                                wb_cyc_o,
    output      logic                                wb_stb_o,
    output      logic                                wb_we_o,
    output      logic [frontend_pkg::xlen-1:0]      wb_adr_o,
    input  wire logic [frontend_pkg::xlen-1:0]      wb_dat_i,
    input  wire logic                                wb_ack_i,
    // redirects from the back end
    input  wire logic                                jump_i,
    input  wire logic [frontend_pkg::xlen-1:0]      jump_target_i,
    input  wire logic                                exception_raised_i,
    input  wire logic                                interrupt_ack_i,
    input  wire logic                                machine_return_i,
    input  wire logic [frontend_pkg::xlen-1:0]      mtvec_i,
    input  wire logic [frontend_pkg::xlen-1:0]      mepc_i,
    // issue port
    input  wire logic                                issue_ready_i,
    output      logic                                issue_valid_o,
    output      logic [frontend_pkg::xlen-1:0]      issue_pc_o,
    output      logic [frontend_pkg::xlen-1:0]      issue_instruction_o,
    output      frontend_pkg::op_class_e             issue_class_o,
    output      logic [frontend_pkg::tag_width-1:0] issue_tag_o
);

    frontend_pkg::issue_entry_t entry;
    frontend_pkg::issue_entry_t issue_entry;

    logic                                flush;
    logic                                space;
    logic                                fe_jump;
    logic [frontend_pkg::xlen-1:0]      fe_jump_target;
    logic [frontend_pkg::tag_width-1:0] current_tag;
    logic                                entry_valid;

    fetch_if fetch_bus ();

    fetch #(
        .start_address (start_address)
    ) u_fetch (
        .clk                (clk),
        .reset              (reset),
        .jump_i             (jump_i),
        .jump_target_i      (jump_target_i),
        .exception_raised_i (exception_raised_i),
        .interrupt_ack_i    (interrupt_ack_i),
        .machine_return_i   (machine_return_i),
        .mtvec_i            (mtvec_i),
        .mepc_i             (mepc_i),
        .fe_jump_i          (fe_jump),
        .fe_jump_target_i   (fe_jump_target),
        .space_i            (space),
        .wb_cyc_o           (wb_cyc_o),
        .wb_stb_o           (wb_stb_o),
        .wb_we_o            (wb_we_o),
        .wb_adr_o           (wb_adr_o),
        .wb_dat_i           (wb_dat_i),
        .wb_ack_i           (wb_ack_i),
        .flush_o            (flush),
        .tag_o              (current_tag),
        .fetch_o            (fetch_bus.source)
    );

    predecode u_predecode (
        .clk              (clk),
        .reset            (reset),
        .flush_i          (flush),
        .current_tag_i    (current_tag),
        .fetch_i          (fetch_bus.sink),
        .fe_jump_o        (fe_jump),
        .fe_jump_target_o (fe_jump_target),
        .entry_valid_o    (entry_valid),
        .entry_o          (entry)
    );

    issue_queue #(
        .queue_depth (queue_depth)
    ) u_issue_queue (
        .clk           (clk),
        .reset         (reset),
        .flush_i       (flush),
        .entry_valid_i (entry_valid),
        .entry_i       (entry),
        .issue_ready_i (issue_ready_i),
        .space_o       (space),
        .issue_valid_o (issue_valid_o),
        .issue_entry_o (issue_entry)
    );

    // entry fields out to plain ports
    assign issue_pc_o          = issue_entry.pc;
    assign issue_instruction_o = issue_entry.instruction;
    assign issue_class_o       = issue_entry.op_class;
    assign issue_tag_o         = issue_entry.tag;

endmodule

`default_nettype wire

/* logic/issue_queue.sv */
// issue queue: circular buffer of decoded instructions with flush and a valid/ready port
`timescale 1ns/1ps
`default_nettype none

module issue_queue #(
    parameter int queue_depth = 4
) (
    input  wire logic                       clk,
    input  wire logic                       reset,
    input  wire logic                       flush_i,
    input  wire logic                       entry_valid_i,
    input  wire frontend_pkg::issue_entry_t entry_i,
    input  wire logic                       issue_ready_i,
    output      logic                       space_o,
    output      logic                       issue_valid_o,
    output      frontend_pkg::issue_entry_t issue_entry_o
);

    // depth is a power of two so the pointers wrap by themselves
    localparam int ptr_width = $clog2(queue_depth);

    frontend_pkg::issue_entry_t storage [queue_depth];

    logic [ptr_width-1:0] wr_ptr_q;
    logic [ptr_width-1:0] rd_ptr_q;
    logic [ptr_width:0]   count_q;
    logic                 full;
    logic                 do_write;
    logic                 do_read;

    assign full          = (count_q == queue_depth[ptr_width:0]);
    assign issue_valid_o = (count_q != '0);
    // oldest entry, held while ready is low
    assign issue_entry_o = storage[rd_ptr_q];

    // two free slots cover one word in the pipe and one read on the bus
    assign space_o = (count_q <= queue_depth[ptr_width:0] - 2'd2);

    assign do_read  = issue_valid_o && issue_ready_i;
    assign do_write = entry_valid_i && !full;

    // pointers and count, flush wins over both ports
    always_ff @(posedge clk) begin
        if (reset || flush_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_write) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (do_read) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            case ({do_write, do_read})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // entry storage
    always_ff @(posedge clk) begin
        if (do_write) begin
            storage[wr_ptr_q] <= entry_i;
        end
    end

endmodule

`default_nettype wire

/* logic/predecode.sv */
// predecoder: opcode class of each fetched word and jal resolution in the front end
`timescale 1ns/1ps
`default_nettype none

module predecode (
    input  wire logic                                clk,
    input  wire logic                                reset,
    input  wire logic                                flush_i,
    input  wire logic [frontend_pkg::tag_width-1:0] current_tag_i,
    fetch_if.sink                                    fetch_i,
    output      logic                                fe_jump_o,
    output      logic [frontend_pkg::xlen-1:0]      fe_jump_target_o,
    output      logic                                entry_valid_o,
    output      frontend_pkg::issue_entry_t          entry_o
);

    frontend_pkg::op_class_e op_class;

    logic [frontend_pkg::xlen-1:0] jal_imm;
    logic [frontend_pkg::xlen-1:0] jal_target;
    logic                          accept;
    logic                          entry_valid_q;
    logic                          fe_jump_q;

    // opcode field to class
    always_comb begin
        case (fetch_i.instruction[6:0])
            7'b0110011: op_class = frontend_pkg::op_alu;
            7'b0010011: op_class = frontend_pkg::op_alu_imm;
            7'b0000011: op_class = frontend_pkg::op_load;
            7'b0100011: op_class = frontend_pkg::op_store;
            7'b1100011: op_class = frontend_pkg::op_branch;
            7'b1101111: op_class = frontend_pkg::op_jal;
            7'b1100111: op_class = frontend_pkg::op_jalr;
            7'b0110111: op_class = frontend_pkg::op_lui;
            7'b0010111: op_class = frontend_pkg::op_auipc;
            7'b1110011: op_class = frontend_pkg::op_system;
            default:    op_class = frontend_pkg::op_illegal;
        endcase
    end

    // j-type immediate, sign from bit 31, bit 0 always zero
    assign jal_imm = {
        {12{fetch_i.instruction[31]}},
        fetch_i.instruction[19:12],
        fetch_i.instruction[20],
        fetch_i.instruction[30:21],
        1'b0
    };
    assign jal_target = fetch_i.pc + jal_imm;

    // stale words: wrong tag, a redirect this cycle, or the word after our own jal
    assign accept = fetch_i.valid && (fetch_i.tag == current_tag_i)
                  && !flush_i && !fe_jump_q;

    // control state
    always_ff @(posedge clk) begin
        if (reset) begin
            entry_valid_q <= 1'b0;
            fe_jump_q     <= 1'b0;
        end else begin
            entry_valid_q <= accept;
            // jump request lands in the same cycle as the queue write
            fe_jump_q <= accept && (op_class == frontend_pkg::op_jal);
        end
    end

    // payload, only loaded on an accepted word
    always_ff @(posedge clk) begin
        if (accept) begin
            entry_o.pc          <= fetch_i.pc;
            entry_o.instruction <= fetch_i.instruction;
            entry_o.op_class    <= op_class;
            entry_o.tag         <= fetch_i.tag;
            fe_jump_target_o    <= jal_target;
        end
    end

    assign entry_valid_o = entry_valid_q;
    assign fe_jump_o     = fe_jump_q;

endmodule

`default_nettype wire

/* logic/fetch.sv */
// fetch unit: pc, flow tag, redirect priority and a wishbone classic read master
`timescale 1ns/1ps
`default_nettype none

module fetch #(
    parameter logic [frontend_pkg::xlen-1:0] start_address = '0
) (
    input  wire logic                                clk,
    input  wire logic                                reset,
    // back-end and trap redirects
    input  wire logic                                jump_i,
    input  wire logic [frontend_pkg::xlen-1:0]      jump_target_i,
    input  wire logic                                exception_raised_i,
    input  wire logic                                interrupt_ack_i,
    input  wire logic                                machine_return_i,
    input  wire logic [frontend_pkg::xlen-1:0]      mtvec_i,
    input  wire logic [frontend_pkg::xlen-1:0]      mepc_i,
    // jal resolved in the predecoder
    input  wire logic                                fe_jump_i,
    input  wire logic [frontend_pkg::xlen-1:0]      fe_jump_target_i,
    // queue can take the words a new read may bring
    input  wire logic                                space_i,
    // wishbone classic read master
    output      logic                                wb_cyc_o,
    output      logic                                wb_stb_o,
    output      logic                                wb_we_o,
    output      logic [frontend_pkg::xlen-1:0]      wb_adr_o,
    input  wire logic [frontend_pkg::xlen-1:0]      wb_dat_i,
    input  wire logic                                wb_ack_i,
    output      logic                                flush_o,
    output      logic [frontend_pkg::tag_width-1:0] tag_o,
    fetch_if.source                                  fetch_o
);

    frontend_pkg::fetch_state_e state_q;

    logic [frontend_pkg::xlen-1:0]      pc_q;
    logic [frontend_pkg::xlen-1:0]      adr_q;
    logic [frontend_pkg::xlen-1:0]      redirect_target;
    logic [frontend_pkg::tag_width-1:0] tag_q;
    logic                               backend_redirect;
    logic                               redirect;
    logic                               bus_active;
    logic                               ack_done;
    logic                               capture;
    // set while the outstanding read belongs to an abandoned path
    logic                               discard_q;

    // trap, return and back-end jump redirects
    assign backend_redirect = machine_return_i | exception_raised_i
                            | interrupt_ack_i | jump_i;
    assign redirect = backend_redirect | fe_jump_i;

    // a front-end jal leaves older queued instructions in place, nothing younger
    // than the jal can have reached the queue when fe_jump is raised
    assign flush_o = backend_redirect;

    // target by priority, mret first, then trap, back-end jump, front-end jal
    always_comb begin
        if (machine_return_i) begin
            redirect_target = mepc_i;
        end else if (exception_raised_i || interrupt_ack_i) begin
            redirect_target = mtvec_i;
        end else if (jump_i) begin
            redirect_target = jump_target_i;
        end else begin
            redirect_target = fe_jump_target_i;
        end
    end

    // cyc and stb stay up from the request until ack
    assign bus_active = (state_q != frontend_pkg::fs_idle);
    assign wb_cyc_o   = bus_active;
    assign wb_stb_o   = bus_active;
    assign wb_we_o    = 1'b0;
    assign wb_adr_o   = adr_q;

    assign ack_done = bus_active && wb_ack_i;
    // keep the word only if no redirect overtook it
    assign capture  = ack_done && !discard_q && !redirect;

    // bus state machine, one read at a time
    always_ff @(posedge clk) begin
        if (reset) begin
            state_q   <= frontend_pkg::fs_idle;
            discard_q <= 1'b0;
        end else begin
            case (state_q)
                frontend_pkg::fs_idle: begin
                    // start only on a settled pc with room downstream
                    if (space_i && !redirect) begin
                        state_q <= frontend_pkg::fs_request;
                    end
                end
                frontend_pkg::fs_request: begin
                    if (wb_ack_i) begin
                        state_q <= frontend_pkg::fs_idle;
                    end else begin
                        state_q <= frontend_pkg::fs_wait_ack;
                    end
                end
                frontend_pkg::fs_wait_ack: begin
                    if (wb_ack_i) begin
                        state_q <= frontend_pkg::fs_idle;
                    end
                end
                default: begin
                    state_q <= frontend_pkg::fs_idle;
                end
            endcase
            // the read still completes, its word is thrown away
            if (ack_done) begin
                discard_q <= 1'b0;
            end else if (bus_active && redirect) begin
                discard_q <= 1'b1;
            end
        end
    end

    // address is latched at request time so it holds through the read
    always_ff @(posedge clk) begin
        if (state_q == frontend_pkg::fs_idle && space_i && !redirect) begin
            adr_q <= pc_q;
        end
    end

    // pc and flow tag
    always_ff @(posedge clk) begin
        if (reset) begin
            pc_q  <= start_address;
            tag_q <= '0;
        end else if (redirect) begin
            pc_q  <= redirect_target;
            tag_q <= tag_q + 1'b1;
        end else if (capture) begin
            // moves on the same edge that captures the word
            pc_q <= pc_q + 32'd4;
        end
    end

    assign tag_o = tag_q;

    // captured word goes out one cycle after ack
    always_ff @(posedge clk) begin
        if (reset) begin
            fetch_o.valid <= 1'b0;
        end else begin
            fetch_o.valid <= capture;
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            fetch_o.instruction <= wb_dat_i;
            fetch_o.pc          <= adr_q;
            fetch_o.tag         <= tag_q;
        end
    end

endmodule

`default_nettype wire

/* logic/fetch_if.sv */
// fetched word bus from the fetch unit to the predecoder, one valid pulse per word
`timescale 1ns/1ps
`default_nettype none

interface fetch_if;

    // one cycle pulse per captured word
    logic                                valid;
    // raw instruction word from memory
    logic [frontend_pkg::xlen-1:0]      instruction;
    // address the word was read from
    logic [frontend_pkg::xlen-1:0]      pc;
    // flow tag current when the read was issued
    logic [frontend_pkg::tag_width-1:0] tag;

    // fetch side drives every field
    modport source (
        output valid,
        output instruction,
        output pc,
        output tag
    );

    // predecoder side only samples, it never stalls fetch
    modport sink (
        input valid,
        input instruction,
        input pc,
        input tag
    );

endinterface

`default_nettype wire

/* logic/frontend_pkg.sv */
// shared widths, opcode classes, fetch states and the issue queue entry for the front end
`default_nettype none

package frontend_pkg;

    // data and address width
    localparam int xlen = 32;
    // flow tag width, wraps at 8
    localparam int tag_width = 3;

    // opcode class, taken from instruction bits 6:0
    typedef enum logic [3:0] {
        op_alu     = 4'd0,
        op_alu_imm = 4'd1,
        op_load    = 4'd2,
        op_store   = 4'd3,
        op_branch  = 4'd4,
        op_jal     = 4'd5,
        op_jalr    = 4'd6,
        op_lui     = 4'd7,
        op_auipc   = 4'd8,
        op_system  = 4'd9,
        op_illegal = 4'd10
    } op_class_e;

    // wishbone read states of the fetch unit
    typedef enum logic [1:0] {
        fs_idle     = 2'd0,
        fs_request  = 2'd1,
        fs_wait_ack = 2'd2
    } fetch_state_e;

    // one queued instruction, 71 bits
    typedef struct packed {
        logic [xlen-1:0]      pc;
        logic [xlen-1:0]      instruction;
        op_class_e            op_class;
        logic [tag_width-1:0] tag;
    } issue_entry_t;

endpackage

`default_nettype wire
